// ==== hw/sh_macros.svh ====
`ifndef SH_MACROS_SVH
`define SH_MACROS_SVH

// Data bus and address width
`define SH_DATA_W 32

// Byte lanes on the data bus, lane 3 is bits 31:24
`define SH_LANES 4

// Immediate field width taken from the instruction word
`define SH_IMM_W 8

`endif

// ==== hw/sh_pkg.sv ====
`default_nettype none

`include "sh_macros.svh"

package sh_pkg;

	typedef logic [`SH_DATA_W-1:0] word_t;
	typedef logic [`SH_LANES-1:0]  lanes_t;
	typedef logic [`SH_IMM_W-1:0]  imm_field_t;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHLL,
		ALU_SHLR,
		ALU_PASS
	} alu_op_t;

	// Immediate extension kind
	typedef enum logic [1:0] {
		IMM_Z4,
		IMM_Z8,
		IMM_S8
	} imm_kind_t;

	// Access size, also scales the immediate
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_WORD,
		SZ_LONG
	} mem_sz_t;

endpackage

`default_nettype wire

// ==== hw/sh_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_alu
	import sh_pkg::*;
(
	input  alu_op_t alu_op,
	input  word_t   op_a,
	input  word_t   op_b,
	output word_t   result,
	output logic    t_flag
);

	// Extra top bit holds carry out or borrow
	logic [`SH_DATA_W:0] sum;
	logic [`SH_DATA_W:0] diff;
	word_t               log_res;

	assign sum  = {1'b0, op_a} + {1'b0, op_b};
	assign diff = {1'b0, op_a} - {1'b0, op_b};

	always_comb begin
		case (alu_op)
			ALU_AND: log_res = op_a & op_b;
			ALU_OR:  log_res = op_a | op_b;
			default: log_res = op_a ^ op_b;
		endcase
	end

	// ************************************************************
	// Result and T select
	// ************************************************************
	always_comb begin
		result = op_b;
		t_flag = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result = sum[`SH_DATA_W-1:0];
				t_flag = sum[`SH_DATA_W];
			end
			ALU_SUB: begin
				result = diff[`SH_DATA_W-1:0];
				t_flag = diff[`SH_DATA_W];
			end
			ALU_AND, ALU_OR, ALU_XOR: begin
				result = log_res;
				t_flag = ~|log_res;
			end
			ALU_SHLL: begin
				result = {op_a[`SH_DATA_W-2:0], 1'b0};
				t_flag = op_a[`SH_DATA_W-1];
			end
			ALU_SHLR: begin
				result = {1'b0, op_a[`SH_DATA_W-1:1]};
				t_flag = op_a[0];
			end
			default: begin
				result = op_b;
				t_flag = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/sh_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_execute
	import sh_pkg::*;
(
	input  word_t      reg_a,
	input  word_t      reg_b,
	input  logic       src_imm,
	input  imm_kind_t  imm_kind,
	input  imm_field_t imm_field,
	input  mem_sz_t    op_sz,
	input  alu_op_t    alu_op,
	output word_t      ex_res,
	output word_t      ex_wd,
	output logic       ex_t
);

	word_t imm_ext;
	word_t imm_val;
	word_t op_b;

	// Immediate extension
	always_comb begin
		case (imm_kind)
			IMM_Z4:  imm_ext = {{(`SH_DATA_W-4){1'b0}}, imm_field[3:0]};
			IMM_S8:  imm_ext = {{(`SH_DATA_W-`SH_IMM_W){imm_field[`SH_IMM_W-1]}}, imm_field};
			default: imm_ext = {{(`SH_DATA_W-`SH_IMM_W){1'b0}}, imm_field};
		endcase
	end

	// Scale by access size
	always_comb begin
		case (op_sz)
			SZ_WORD: imm_val = {imm_ext[`SH_DATA_W-2:0], 1'b0};
			SZ_LONG: imm_val = {imm_ext[`SH_DATA_W-3:0], 2'b00};
			default: imm_val = imm_ext;
		endcase
	end

	assign op_b = src_imm ? imm_val : reg_b;

	// Store data is always the second register
	assign ex_wd = reg_b;

	sh_alu i_alu (
		.alu_op (alu_op),
		.op_a   (reg_a),
		.op_b   (op_b),
		.result (ex_res),
		.t_flag (ex_t)
	);

endmodule

`default_nettype wire

// ==== hw/sh_ma_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_ma_stage
	import sh_pkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    issue,
	input  word_t   ex_res,
	input  word_t   ex_wd,
	input  logic    ex_t,
	input  logic    mem_rd,
	input  logic    mem_wr,
	input  mem_sz_t op_sz,
	input  logic    bus_wait,
	output logic    busy,
	output logic    ma_done,
	output logic    ma_valid,
	output word_t   ma_res,
	output word_t   ma_wd,
	output logic    ma_t,
	output logic    ma_rd,
	output logic    ma_wr,
	output mem_sz_t ma_sz
);

	logic ma_mem;

	assign ma_mem  = ma_rd | ma_wr;
	assign busy    = ma_valid & ma_mem & bus_wait;
	assign ma_done = ma_valid & (~ma_mem | ~bus_wait);

	// Bubbles carry no access
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ma_valid <= 1'b0;
			ma_rd    <= 1'b0;
			ma_wr    <= 1'b0;
		end else if (!busy) begin
			ma_valid <= issue;
			ma_rd    <= issue & mem_rd;
			ma_wr    <= issue & mem_wr;
		end
	end

	always_ff @(posedge CLK) begin
		if (!busy) begin
			ma_res <= ex_res;
			ma_wd  <= ex_wd;
			ma_t   <= ex_t;
			ma_sz  <= op_sz;
		end
	end

	// Decoder never issues a read-modify-write here
	a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!RST_N)
		(issue && !busy) |-> !(mem_rd && mem_wr))
		else $error("load and store issued together");

	// Stalled issue and its fields are held by the source
	a_hold_stable: assert property (@(posedge CLK) disable iff (!RST_N)
		(busy && issue) |=> (issue && $stable({ex_res, ex_wd, ex_t, op_sz, mem_rd, mem_wr})))
		else $error("issue payload changed under bus wait");

endmodule

`default_nettype wire

// ==== hw/sh_bus_access.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_bus_access
	import sh_pkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    ma_valid,
	input  logic    ma_done,
	input  logic    ma_rd,
	input  logic    ma_wr,
	input  logic    ma_t,
	input  word_t   ma_res,
	input  word_t   ma_wd,
	input  mem_sz_t ma_sz,
	input  word_t   bus_di,
	output word_t   bus_a,
	output word_t   bus_do,
	output logic    bus_wr,
	output logic    bus_req,
	output lanes_t  bus_ba,
	output logic    res_valid,
	output logic    res_t,
	output word_t   res_data
);

	lanes_t lanes;
	word_t  rd_shift;
	word_t  rd_data;

	// ************************************************************
	// Bus drive
	// ************************************************************
	assign bus_req = ma_valid & (ma_rd | ma_wr);
	assign bus_a   = ma_res;
	assign bus_wr  = ma_wr & bus_req;

	// Big endian, offset 0 sits on lane 3
	always_comb begin
		case (ma_sz)
			SZ_BYTE: lanes = lanes_t'(4'b1000 >> ma_res[1:0]);
			SZ_WORD: lanes = ma_res[1] ? lanes_t'(4'b0011) : lanes_t'(4'b1100);
			default: lanes = '1;
		endcase
	end

	assign bus_ba = lanes & {`SH_LANES{bus_req}};

	always_comb begin
		case (ma_sz)
			SZ_BYTE: bus_do = {`SH_LANES{ma_wd[7:0]}};
			SZ_WORD: bus_do = {2{ma_wd[15:0]}};
			default: bus_do = ma_wd;
		endcase
	end

	// ************************************************************
	// Load alignment
	// ************************************************************
	always_comb begin
		case (ma_sz)
			SZ_BYTE: rd_shift = bus_di >> {~ma_res[1:0], 3'b000};
			SZ_WORD: rd_shift = bus_di >> {~ma_res[1], 4'b0000};
			default: rd_shift = bus_di;
		endcase
		case (ma_sz)
			SZ_BYTE: rd_data = {{(`SH_DATA_W-8){rd_shift[7]}}, rd_shift[7:0]};
			SZ_WORD: rd_data = {{(`SH_DATA_W-16){rd_shift[15]}}, rd_shift[15:0]};
			default: rd_data = rd_shift;
		endcase
	end

	// Write-back register
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= ma_done;
		end
	end

	always_ff @(posedge CLK) begin
		if (ma_done) begin
			res_data <= ma_rd ? rd_data : ma_res;
			res_t    <= ma_t;
		end
	end

	// Address, lanes and write data hold until the access ends
	a_bus_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		(bus_req && !ma_done) |=> (bus_req && $stable({bus_a, bus_do, bus_ba, bus_wr})))
		else $error("bus access changed before it ended");

endmodule

`default_nettype wire

// ==== hw/sh_ex_ma.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_ex_ma
	import sh_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       issue,
	input  alu_op_t    alu_op,
	input  logic       src_imm,
	input  imm_kind_t  imm_kind,
	input  imm_field_t imm_field,
	input  mem_sz_t    op_sz,
	input  logic       mem_rd,
	input  logic       mem_wr,
	input  word_t      reg_a,
	input  word_t      reg_b,
	input  word_t      bus_di,
	input  logic       bus_wait,
	output logic       busy,
	output word_t      bus_a,
	output word_t      bus_do,
	output logic       bus_wr,
	output lanes_t     bus_ba,
	output logic       bus_req,
	output logic       res_valid,
	output word_t      res_data,
	output logic       res_t
);

	word_t   ex_res;
	word_t   ex_wd;
	logic    ex_t;

	logic    ma_valid;
	logic    ma_done;
	word_t   ma_res;
	word_t   ma_wd;
	logic    ma_t;
	logic    ma_rd;
	logic    ma_wr;
	mem_sz_t ma_sz;

	sh_execute i_execute (
		.reg_a     (reg_a),
		.reg_b     (reg_b),
		.src_imm   (src_imm),
		.imm_kind  (imm_kind),
		.imm_field (imm_field),
		.op_sz     (op_sz),
		.alu_op    (alu_op),
		.ex_res    (ex_res),
		.ex_wd     (ex_wd),
		.ex_t      (ex_t)
	);

	sh_ma_stage i_ma_stage (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.issue    (issue),
		.ex_res   (ex_res),
		.ex_wd    (ex_wd),
		.ex_t     (ex_t),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.op_sz    (op_sz),
		.bus_wait (bus_wait),
		.busy     (busy),
		.ma_done  (ma_done),
		.ma_valid (ma_valid),
		.ma_res   (ma_res),
		.ma_wd    (ma_wd),
		.ma_t     (ma_t),
		.ma_rd    (ma_rd),
		.ma_wr    (ma_wr),
		.ma_sz    (ma_sz)
	);

	sh_bus_access i_bus_access (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ma_valid  (ma_valid),
		.ma_done   (ma_done),
		.ma_rd     (ma_rd),
		.ma_wr     (ma_wr),
		.ma_t      (ma_t),
		.ma_res    (ma_res),
		.ma_wd     (ma_wd),
		.ma_sz     (ma_sz),
		.bus_di    (bus_di),
		.bus_a     (bus_a),
		.bus_do    (bus_do),
		.bus_wr    (bus_wr),
		.bus_req   (bus_req),
		.bus_ba    (bus_ba),
		.res_valid (res_valid),
		.res_t     (res_t),
		.res_data  (res_data)
	);

endmodule

`default_nettype wire

// ==== sim/sh_ex_ma_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_macros.svh"

module sh_ex_ma_tb
	import sh_pkg::*;
;

	localparam int NUM_OPS     = 400;
	localparam int CYCLE_LIMIT = NUM_OPS * 6 + 50;
	localparam int MAX_WAIT    = 3;

	logic       CLK;
	logic       RST_N;
	logic       issue;
	alu_op_t    alu_op;
	logic       src_imm;
	imm_kind_t  imm_kind;
	imm_field_t imm_field;
	mem_sz_t    op_sz;
	logic       mem_rd;
	logic       mem_wr;
	word_t      reg_a;
	word_t      reg_b;
	word_t      bus_di;
	logic       bus_wait;
	logic       busy;
	word_t      bus_a;
	word_t      bus_do;
	logic       bus_wr;
	lanes_t     bus_ba;
	logic       bus_req;
	logic       res_valid;
	word_t      res_data;
	logic       res_t;

	integer seed;
	int     errors;
	int     cycles;
	int     n_accepted;
	int     n_checked;
	int     wait_run;
	int     ma_idx;
	logic   acc_last;
	logic   exp_req;
	word_t  op_b_model;
	logic [`SH_DATA_W:0] alu_out;

	// Outstanding operations, oldest first
	word_t   q_data[$];
	logic    q_t[$];
	logic    q_rd[$];
	logic    q_wr[$];
	mem_sz_t q_sz[$];
	word_t   q_wd[$];

	sh_ex_ma i_dut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.issue     (issue),
		.alu_op    (alu_op),
		.src_imm   (src_imm),
		.imm_kind  (imm_kind),
		.imm_field (imm_field),
		.op_sz     (op_sz),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.reg_a     (reg_a),
		.reg_b     (reg_b),
		.bus_di    (bus_di),
		.bus_wait  (bus_wait),
		.busy      (busy),
		.bus_a     (bus_a),
		.bus_do    (bus_do),
		.bus_wr    (bus_wr),
		.bus_ba    (bus_ba),
		.bus_req   (bus_req),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_t     (res_t)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// ************************************************************
	// Reference model
	// ************************************************************
	function automatic logic [`SH_DATA_W:0] model_alu(alu_op_t op, word_t a, word_t b);
		word_t res;
		logic  t;
		case (op)
			ALU_ADD: begin
				res = a + b;
				t   = (res < a);
			end
			ALU_SUB: begin
				res = a - b;
				t   = (a < b);
			end
			ALU_AND: begin
				res = a & b;
				t   = (res == 0);
			end
			ALU_OR: begin
				res = a | b;
				t   = (res == 0);
			end
			ALU_XOR: begin
				res = a ^ b;
				t   = (res == 0);
			end
			ALU_SHLL: begin
				res = a << 1;
				t   = a[`SH_DATA_W-1];
			end
			ALU_SHLR: begin
				res = a >> 1;
				t   = a[0];
			end
			default: begin
				res = b;
				t   = 1'b0;
			end
		endcase
		return {t, res};
	endfunction

	function automatic word_t imm_value(imm_kind_t kind, imm_field_t f, mem_sz_t sz);
		word_t v;
		case (kind)
			IMM_Z4:  v = f & 8'h0f;
			IMM_S8:  v = {{24{f[7]}}, f};
			default: v = f;
		endcase
		case (sz)
			SZ_WORD: return v * 2;
			SZ_LONG: return v * 4;
			default: return v;
		endcase
	endfunction

	function automatic lanes_t lane_mask(mem_sz_t sz, logic [1:0] off);
		case (sz)
			SZ_BYTE: return lanes_t'(1 << (3 - off));
			SZ_WORD: return off[1] ? 4'b0011 : 4'b1100;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic word_t store_pattern(mem_sz_t sz, word_t wd);
		case (sz)
			SZ_BYTE: return {wd[7:0], wd[7:0], wd[7:0], wd[7:0]};
			SZ_WORD: return {wd[15:0], wd[15:0]};
			default: return wd;
		endcase
	endfunction

	// Offset 0 is the most significant byte
	function automatic word_t load_value(mem_sz_t sz, logic [1:0] off, word_t di);
		logic [7:0]  b;
		logic [15:0] h;
		int          k;
		k = off;
		b = di[31 - 8 * k -: 8];
		h = off[1] ? di[15:0] : di[31:16];
		case (sz)
			SZ_BYTE: return {{24{b[7]}}, b};
			SZ_WORD: return {{16{h[15]}}, h};
			default: return di;
		endcase
	endfunction

	// ************************************************************
	// Compare tasks
	// ************************************************************
	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_lanes(string name, lanes_t got, lanes_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// ************************************************************
	// Stimulus and bus responder
	// ************************************************************
	task automatic draw_operation();
		logic [31:0] r;
		r = $random(seed);
		issue = (n_accepted < NUM_OPS) && ((r % 100) < 70);
		if (issue) begin
			r         = $random(seed);
			alu_op    = alu_op_t'(r[2:0]);
			src_imm   = r[3];
			mem_rd    = (r[5:4] == 2'd0);
			mem_wr    = (r[5:4] == 2'd1);
			imm_field = r[15:8];
			// Address is always register plus scaled immediate
			if (mem_rd || mem_wr) begin
				alu_op  = ALU_ADD;
				src_imm = 1'b1;
			end
			r        = $random(seed);
			imm_kind = imm_kind_t'(r % 3);
			r        = $random(seed);
			op_sz    = mem_sz_t'(r % 3);
			reg_a    = $random(seed);
			r        = $random(seed);
			case (r % 8)
				0:       reg_b = reg_a;
				1:       reg_b = ~reg_a;
				default: reg_b = $random(seed);
			endcase
		end
	endtask

	task automatic drive_bus();
		logic [31:0] r;
		r      = $random(seed);
		bus_di = $random(seed);
		if (bus_req) begin
			bus_wait = (wait_run < MAX_WAIT) ? r[0] : 1'b0;
			wait_run = bus_wait ? wait_run + 1 : 0;
		end else begin
			bus_wait = r[1];
			wait_run = 0;
		end
	endtask

	// Monitor sees the values held just before each rising edge
	always @(posedge CLK) begin
		if (RST_N) begin
			acc_last = issue && !busy;
			// Operation in MA sits behind the one in write-back
			ma_idx  = res_valid ? 1 : 0;
			exp_req = 1'b0;
			if (ma_idx < q_data.size())
				exp_req = q_rd[ma_idx] || q_wr[ma_idx];
			check_bit("bus_req", bus_req, exp_req);
			check_bit("busy", busy, exp_req && bus_wait);
			if (exp_req && !bus_wait) begin
				check_word("bus_a", bus_a, q_data[ma_idx]);
				check_bit("bus_wr", bus_wr, q_wr[ma_idx]);
				check_lanes("bus_ba", bus_ba, lane_mask(q_sz[ma_idx], q_data[ma_idx][1:0]));
				if (q_wr[ma_idx])
					check_word("bus_do", bus_do, store_pattern(q_sz[ma_idx], q_wd[ma_idx]));
				else
					q_data[ma_idx] = load_value(q_sz[ma_idx], q_data[ma_idx][1:0], bus_di);
			end
			if (res_valid) begin
				if (q_data.size() == 0) begin
					$display("t=%0t result arrived with no operation outstanding", $time);
					errors++;
				end else begin
					check_word("res_data", res_data, q_data.pop_front());
					check_bit("res_t", res_t, q_t.pop_front());
					void'(q_rd.pop_front());
					void'(q_wr.pop_front());
					void'(q_sz.pop_front());
					void'(q_wd.pop_front());
					n_checked++;
				end
			end
			if (acc_last) begin
				op_b_model = src_imm ? imm_value(imm_kind, imm_field, op_sz) : reg_b;
				alu_out    = model_alu(alu_op, reg_a, op_b_model);
				q_data.push_back(alu_out[`SH_DATA_W-1:0]);
				q_t.push_back(alu_out[`SH_DATA_W]);
				q_rd.push_back(mem_rd);
				q_wr.push_back(mem_wr);
				q_sz.push_back(op_sz);
				q_wd.push_back(reg_b);
				n_accepted++;
			end
		end
	end

	initial begin
		seed       = 62070;
		errors     = 0;
		cycles     = 0;
		n_accepted = 0;
		n_checked  = 0;
		wait_run   = 0;
		acc_last   = 1'b0;
		RST_N      = 1'b0;
		issue      = 1'b0;
		alu_op     = ALU_ADD;
		src_imm    = 1'b0;
		imm_kind   = IMM_Z4;
		imm_field  = '0;
		op_sz      = SZ_BYTE;
		mem_rd     = 1'b0;
		mem_wr     = 1'b0;
		reg_a      = '0;
		reg_b      = '0;
		bus_di     = '0;
		bus_wait   = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		// Idle outputs before the first issue
		check_bit("busy", busy, 1'b0);
		check_bit("bus_req", bus_req, 1'b0);
		check_bit("bus_wr", bus_wr, 1'b0);
		check_lanes("bus_ba", bus_ba, '0);
		check_bit("res_valid", res_valid, 1'b0);

		while (n_checked < NUM_OPS && cycles < CYCLE_LIMIT) begin
			@(negedge CLK);
			cycles++;
			drive_bus();
			// Fields stay put until the DUT takes them
			if (!(issue && !acc_last))
				draw_operation();
		end

		if (n_checked < NUM_OPS) begin
			$display("Timeout: results stopped arriving after %0d of %0d operations",
				n_checked, NUM_OPS);
			errors++;
		end
		$display("Checked %0d results in %0d cycles, %0d errors", n_checked, cycles, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/sh_pkg.sv
hw/sh_alu.sv
hw/sh_execute.sv
hw/sh_ma_stage.sv
hw/sh_bus_access.sv
hw/sh_ex_ma.sv
sim/sh_ex_ma_tb.sv
